//--- hw/ctr_pkg.sv
// Shared definitions for the slice-serial CTR counter unit
// Widths, vector typedefs, command struct and FSM state encodings

`default_nettype none

package ctr_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Full counter block
  localparam int unsigned CtrWidth      = 128;
  // Bits handled per increment step
  localparam int unsigned SliceSize     = 16;
  localparam int unsigned NumSlices     = CtrWidth / SliceSize;
  localparam int unsigned SliceIdxWidth = $clog2(NumSlices);

  ////////////////////
  // Types
  ////////////////////

  typedef logic [CtrWidth-1:0]      ctr_t;
  typedef logic [SliceSize-1:0]     ctr_slice_t;
  typedef logic [SliceIdxWidth-1:0] slice_idx_t;

  // Command opcode
  typedef enum logic {
    CTR_OP_LOAD = 1'b0,
    CTR_OP_INCR = 1'b1
  } ctr_op_e;

  // Value field only matters for a load
  typedef struct packed {
    ctr_op_e op;
    ctr_t    value;
  } ctr_cmd_t;

  // Increment machine
  typedef enum logic [1:0] {
    CTR_IDLE  = 2'b00,
    CTR_INCR  = 2'b01,
    CTR_ERROR = 2'b10
  } ctr_state_e;

  // Command intake
  typedef enum logic [2:0] {
    IN_IDLE      = 3'd0,
    IN_LOAD      = 3'd1,
    IN_INCR      = 3'd2,
    IN_WAIT_INCR = 3'd3,
    IN_PUBLISH   = 3'd4,
    IN_ACK       = 3'd5,
    IN_LOCKED    = 3'd6
  } intake_state_e;

endpackage

`default_nettype wire

//--- hw/ctr_cmd_intake.sv
// Command intake for the CTR counter unit
// Four-phase command slave, per-command sequencing and protocol check

`timescale 1ns/1ps
`default_nettype none

module ctr_cmd_intake import ctr_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  logic     cmd_req_i,
  input  ctr_cmd_t cmd_i,
  output logic     cmd_ack_o,

  output logic     load_o,
  output ctr_t     load_value_o,
  output logic     incr_o,
  input  logic     incr_ready_i,
  output logic     publish_o,
  input  logic     done_i,

  output logic     proto_err_o,
  input  logic     lock_i
);

  intake_state_e state_d, state_q;
  logic          cmd_ack_d, cmd_ack_q;
  ctr_t          load_value_q;
  logic          proto_err;

  // Request dropped while busy and not yet acknowledged
  assign proto_err = !cmd_req_i && !cmd_ack_q &&
                     !(state_q inside {IN_IDLE, IN_LOCKED});

  ////////////////////
  // Sequencing
  ////////////////////

  always_comb begin
    state_d   = state_q;
    cmd_ack_d = cmd_ack_q;

    unique case (state_q)
      IN_IDLE: begin
        // Capture edge, steer by opcode
        if (cmd_req_i) begin
          state_d = (cmd_i.op == CTR_OP_INCR) ? IN_INCR : IN_LOAD;
        end
      end
      IN_LOAD:      state_d = IN_PUBLISH;
      IN_INCR:      state_d = IN_WAIT_INCR;
      IN_WAIT_INCR: begin
        // Incrementer back in idle, store is final
        if (incr_ready_i) begin
          state_d = IN_PUBLISH;
        end
      end
      IN_PUBLISH:   state_d = IN_ACK;
      IN_ACK: begin
        if (!cmd_ack_q) begin
          // Value handshake finished
          if (done_i) begin
            cmd_ack_d = 1'b1;
          end
        end else if (!cmd_req_i) begin
          // Closing phase of the four-phase handshake
          cmd_ack_d = 1'b0;
          state_d   = IN_IDLE;
        end
      end
      IN_LOCKED:    state_d = IN_LOCKED;
      default:      state_d = IN_LOCKED;
    endcase

    // Freeze on a violation until the lock arrives
    if (proto_err) begin
      state_d   = state_q;
      cmd_ack_d = cmd_ack_q;
    end

    // Terminal, no further commands or acknowledges
    if (lock_i) begin
      state_d   = IN_LOCKED;
      cmd_ack_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IN_IDLE;
      cmd_ack_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      cmd_ack_q <= cmd_ack_d;
    end
  end

  // Load payload, taken on the capture edge
  always_ff @(posedge clk_i) begin
    if (state_q == IN_IDLE && cmd_req_i && !lock_i) begin
      load_value_q <= cmd_i.value;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign load_o       = (state_q == IN_LOAD) && !proto_err && !lock_i;
  assign incr_o       = (state_q == IN_INCR) && !proto_err && !lock_i;
  assign publish_o    = (state_q == IN_PUBLISH) && !proto_err && !lock_i;
  assign load_value_o = load_value_q;
  assign cmd_ack_o    = cmd_ack_q;
  assign proto_err_o  = proto_err;

  // Ack only rises on a request that was still up
  CmdAckNeedsReq: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cmd_ack_o) |-> $past(cmd_req_i))
    else $error("cmd_ack_o rose without a pending request");

endmodule

`default_nettype wire

//--- hw/ctr_slice_store.sv
// Counter block register for the CTR counter unit
// Stored as slices with indexed read, single-slice write and full load

`timescale 1ns/1ps
`default_nettype none

module ctr_slice_store import ctr_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Full load from the intake
  input  logic       load_i,
  input  ctr_t       load_value_i,

  // Slice port for the incrementer
  input  slice_idx_t slice_idx_i,
  input  logic       slice_we_i,
  input  ctr_slice_t slice_i,
  output ctr_slice_t slice_o,

  // Whole value for the output side
  output ctr_t       value_o
);

  // Slice 0 holds the least significant bits
  ctr_slice_t [NumSlices-1:0] slice_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slice_q <= '0;
    end else if (load_i) begin
      slice_q <= load_value_i;
    end else if (slice_we_i) begin
      slice_q[slice_idx_i] <= slice_i;
    end
  end

  // Combinational read for the adder
  assign slice_o = slice_q[slice_idx_i];

  // Flat view of all slices
  assign value_o = slice_q;

  ////////////////////
  // Checks
  ////////////////////

  // Intake and incrementer never drive the store together
  LoadWriteExclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_i && slice_we_i))
    else $error("load and slice write in the same cycle");

endmodule

`default_nettype wire

//--- hw/ctr_incr_fsm.sv
// Slice-serial increment FSM for the CTR counter unit
// Carry register, slice index, sticky alert and terminal error state

`timescale 1ns/1ps
`default_nettype none

module ctr_incr_fsm import ctr_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       incr_i,
  output logic       ready_o,
  input  logic       err_i,
  output logic       alert_o,

  output slice_idx_t ctr_slice_idx_o,
  input  ctr_slice_t ctr_slice_i,
  output ctr_slice_t ctr_slice_o,
  output logic       ctr_we_o
);

  ctr_state_e         state_d, state_q;
  slice_idx_t         slice_idx_d, slice_idx_q;
  logic               carry_d, carry_q;
  // Own flop, kept apart from the state register
  logic               alert_q;

  // Sum with carry-out in the top bit
  logic [SliceSize:0] ctr_sum;

  ////////////////////
  // Datapath
  ////////////////////

  // One slice per cycle, no wide adder
  assign ctr_sum     = {1'b0, ctr_slice_i} + (SliceSize + 1)'(carry_q);
  assign ctr_slice_o = ctr_sum[SliceSize-1:0];

  ////////////////////
  // Control
  ////////////////////

  always_comb begin
    ready_o     = 1'b0;
    ctr_we_o    = 1'b0;
    state_d     = state_q;
    slice_idx_d = slice_idx_q;
    carry_d     = carry_q;

    unique case (state_q)
      CTR_IDLE: begin
        ready_o = 1'b1;
        if (incr_i) begin
          // Start at slice 0 with a carry of one
          slice_idx_d = '0;
          carry_d     = 1'b1;
          state_d     = CTR_INCR;
        end
      end

      CTR_INCR: begin
        ctr_we_o    = 1'b1;
        slice_idx_d = slice_idx_q + slice_idx_t'(1);
        // Ripple into the next slice
        carry_d     = ctr_sum[SliceSize];
        if (slice_idx_q == slice_idx_t'(NumSlices - 1)) begin
          state_d = CTR_IDLE;
        end
      end

      CTR_ERROR: begin
        // Terminal, left only by reset
        state_d = CTR_ERROR;
      end

      default: begin
        // Illegal encoding
        state_d = CTR_ERROR;
      end
    endcase

    // Protocol violation from the intake
    if (err_i) begin
      state_d = CTR_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= CTR_IDLE;
      slice_idx_q <= '0;
      carry_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      slice_idx_q <= slice_idx_d;
      carry_q     <= carry_d;
    end
  end

  // Sticky until reset, set as the FSM heads for the error state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else if (state_d == CTR_ERROR) begin
      alert_q <= 1'b1;
    end
  end

  assign alert_o         = alert_q;
  assign ctr_slice_idx_o = slice_idx_q;

  ////////////////////
  // Checks
  ////////////////////

  // Quiet alert means a legal working state
  CtrStateValid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !alert_o |-> state_q inside {CTR_IDLE, CTR_INCR})
    else $error("increment FSM in bad state without alert");

endmodule

`default_nettype wire

//--- hw/ctr_value_out.sv
// Output side of the CTR counter unit
// Four-phase master publishing the counter value, done pulse per transfer

`timescale 1ns/1ps
`default_nettype none

module ctr_value_out import ctr_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic publish_i,
  input  ctr_t value_i,
  output logic done_o,

  output logic val_req_o,
  output ctr_t val_o,
  input  logic val_ack_i
);

  logic val_req_q;
  // Request dropped, waiting for ack to go low
  logic drop_q;
  logic done_q;
  ctr_t val_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      val_req_q <= 1'b0;
      drop_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (publish_i) begin
        val_req_q <= 1'b1;
      end else if (val_req_q && val_ack_i) begin
        // Consumer took it
        val_req_q <= 1'b0;
        drop_q    <= 1'b1;
      end else if (drop_q && !val_ack_i) begin
        // Four phases complete
        drop_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  // Snapshot of the store
  always_ff @(posedge clk_i) begin
    if (publish_i) begin
      val_q <= value_i;
    end
  end

  assign val_req_o = val_req_q;
  assign val_o     = val_q;
  assign done_o    = done_q;

  // Data held for the whole request phase
  ValStable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    val_req_o && $past(val_req_o) |-> $stable(val_o))
    else $error("val_o changed while val_req_o high");

endmodule

`default_nettype wire

//--- hw/ctr_unit_top.sv
// Top level of the slice-serial CTR counter unit
// Intake, slice store, increment FSM and output side

`timescale 1ns/1ps
`default_nettype none

module ctr_unit_top import ctr_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Command slave
  input  logic     cmd_req_i,
  input  ctr_cmd_t cmd_i,
  output logic     cmd_ack_o,

  // Value master
  output logic     val_req_o,
  output ctr_t     val_o,
  input  logic     val_ack_i,

  output logic     alert_o
);

  // Intake to store
  logic       load;
  ctr_t       load_value;

  // Intake and incrementer
  logic       incr;
  logic       incr_ready;
  logic       proto_err;
  logic       alert;

  // Incrementer slice port
  slice_idx_t slice_idx;
  ctr_slice_t slice_rd;
  ctr_slice_t slice_wr;
  logic       slice_we;

  // Publication path
  ctr_t       ctr_value;
  logic       publish;
  logic       done;

  ctr_cmd_intake i_cmd_intake (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_req_i    (cmd_req_i),
    .cmd_i        (cmd_i),
    .cmd_ack_o    (cmd_ack_o),
    .load_o       (load),
    .load_value_o (load_value),
    .incr_o       (incr),
    .incr_ready_i (incr_ready),
    .publish_o    (publish),
    .done_i       (done),
    .proto_err_o  (proto_err),
    .lock_i       (alert)
  );

  ctr_slice_store i_slice_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (load),
    .load_value_i (load_value),
    .slice_idx_i  (slice_idx),
    .slice_we_i   (slice_we),
    .slice_i      (slice_wr),
    .slice_o      (slice_rd),
    .value_o      (ctr_value)
  );

  ctr_incr_fsm i_incr_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .incr_i          (incr),
    .ready_o         (incr_ready),
    .err_i           (proto_err),
    .alert_o         (alert),
    .ctr_slice_idx_o (slice_idx),
    .ctr_slice_i     (slice_rd),
    .ctr_slice_o     (slice_wr),
    .ctr_we_o        (slice_we)
  );

  ctr_value_out i_value_out (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .publish_i (publish),
    .value_i   (ctr_value),
    .done_o    (done),
    .val_req_o (val_req_o),
    .val_o     (val_o),
    .val_ack_i (val_ack_i)
  );

  // Sticky alert from the increment FSM
  assign alert_o = alert;

endmodule

`default_nettype wire

//--- include/tb_ctr_util.svh
// Testbench helpers for the CTR counter unit
// Fibonacci LFSR stimulus source and compare tasks on package types

`ifndef TB_CTR_UTIL_SVH
`define TB_CTR_UTIL_SVH

  ////////////////////
  // Random source
  ////////////////////

  // Seed for the stimulus stream, consumer stream derived from it
  localparam logic [31:0] LfsrSeed = 32'h75e8_4d24;

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  // Shift out n bits, one step per bit
  task automatic take_bits(inout logic [31:0] state, input int unsigned n,
                           output ctr_t bits);
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      bits  = {bits[CtrWidth-2:0], state[31]};
      state = lfsr_next(state);
    end
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  // Full counter values
  task automatic check_value(input ctr_t got, input ctr_t exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      $display("  got      %h", got);
      $display("  expected %h", exp);
      abort_run();
    end
  endtask

  // Single-bit status such as alert and handshake lines
  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s (got %b, expected %b)",
               $time, msg, got, exp);
      abort_run();
    end
  endtask

`endif

//--- verification/tb_ctr_unit.sv
// Testbench for the slice-serial CTR counter unit
// Clock, reset, DUT, command sequences, value consumer, model and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_ctr_unit import ctr_pkg::*; ();

  localparam int unsigned ClkPeriod    = 8;
  localparam int unsigned NumLoads     = 8;
  localparam int unsigned NumIncrRuns  = 6;
  localparam int unsigned MaxRunLen    = 4;
  localparam int unsigned LockWait     = 100;
  localparam int unsigned CyclesPerCmd = 200;
  // Reset incr, loads, runs, carry pairs, two lock-up requests
  localparam int unsigned MaxCmds = 1 + NumLoads + NumIncrRuns * MaxRunLen +
                                    2 * NumSlices + 2;

  logic     clk_i;
  logic     rst_ni;
  logic     cmd_req_i;
  ctr_cmd_t cmd_i;
  logic     cmd_ack_o;
  logic     val_req_o;
  ctr_t     val_o;
  logic     val_ack_i;
  logic     alert_o;

  // Reference counter
  ctr_t        model_q;
  // Values taken by the consumer, in order
  ctr_t        published_q[$];
  int unsigned cmd_count;
  int unsigned resp_count;
  logic [31:0] stim_lfsr;
  logic [31:0] resp_lfsr;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ctr_unit_top i_ctr_unit_top (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_req_i (cmd_req_i),
    .cmd_i     (cmd_i),
    .cmd_ack_o (cmd_ack_o),
    .val_req_o (val_req_o),
    .val_o     (val_o),
    .val_ack_i (val_ack_i),
    .alert_o   (alert_o)
  );

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  `include "tb_ctr_util.svh"

  ////////////////////
  // Command master
  ////////////////////

  // Full four-phase command, returns the value the consumer saw
  task automatic send_cmd(input ctr_op_e op, input ctr_t value, output ctr_t published);
    ctr_cmd_t cmd;
    cmd.op    = op;
    cmd.value = value;
    cmd_count++;
    @(posedge clk_i);
    cmd_req_i <= 1'b1;
    cmd_i     <= cmd;
    do @(negedge clk_i); while (!cmd_ack_o);
    // Value handshake must already be closed
    check_flag(resp_count == cmd_count, 1'b1, "cmd_ack_o before value handshake done");
    check_flag(val_req_o, 1'b0, "val_req_o still high at cmd_ack_o");
    check_flag(alert_o, 1'b0, "alert_o raised during a legal command");
    published = published_q.pop_front();
    @(posedge clk_i);
    cmd_req_i <= 1'b0;
    do @(negedge clk_i); while (cmd_ack_o);
  endtask

  task automatic load_and_check(input ctr_t value);
    ctr_t got;
    send_cmd(CTR_OP_LOAD, value, got);
    model_q = value;
    check_value(got, model_q, "published value after load");
  endtask

  task automatic incr_and_check();
    ctr_t got;
    send_cmd(CTR_OP_INCR, '0, got);
    // Wraps modulo 2^128
    model_q = model_q + ctr_t'(1);
    check_value(got, model_q, "published value after increment");
  endtask

  ////////////////////
  // Value consumer
  ////////////////////

  initial begin : value_consumer
    ctr_t held;
    ctr_t delay_bits;
    forever begin
      @(negedge clk_i);
      if (val_req_o) begin
        held = val_o;
        take_bits(resp_lfsr, 3, delay_bits);
        repeat (delay_bits % 6) begin
          @(negedge clk_i);
          check_value(val_o, held, "val_o changed while val_req_o high");
        end
        @(posedge clk_i);
        val_ack_i <= 1'b1;
        do begin
          @(negedge clk_i);
          if (val_req_o) begin
            check_value(val_o, held, "val_o changed while val_req_o high");
          end
        end while (val_req_o);
        // Late ack release stretches the command
        take_bits(resp_lfsr, 3, delay_bits);
        repeat (delay_bits % 6) @(negedge clk_i);
        @(posedge clk_i);
        val_ack_i <= 1'b0;
        published_q.push_back(held);
        resp_count++;
      end
    end
  end

  initial begin : watchdog
    repeat (MaxCmds * CyclesPerCmd) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", MaxCmds * CyclesPerCmd);
    abort_run();
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    ctr_t value;
    ctr_t run_bits;
    ctr_t mask;
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    cmd_req_i  = 1'b0;
    cmd_i      = '0;
    val_ack_i  = 1'b0;
    stim_lfsr  = LfsrSeed;
    resp_lfsr  = {LfsrSeed[15:0], LfsrSeed[31:16]};
    model_q    = '0;
    cmd_count  = 0;
    resp_count = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);

    // Idle after reset, counter at zero
    check_flag(alert_o, 1'b0, "alert_o high after reset");
    check_flag(cmd_ack_o, 1'b0, "cmd_ack_o high after reset");
    check_flag(val_req_o, 1'b0, "val_req_o high after reset");
    incr_and_check();

    for (int i = 0; i < NumLoads; i++) begin
      take_bits(stim_lfsr, CtrWidth, value);
      load_and_check(value);
    end

    for (int r = 0; r < NumIncrRuns; r++) begin
      take_bits(stim_lfsr, 2, run_bits);
      repeat (int'(run_bits[1:0]) + 1) incr_and_check();
    end

    // Trailing all-ones slices, last one wraps to zero
    for (int k = 1; k <= NumSlices; k++) begin
      take_bits(stim_lfsr, CtrWidth, value);
      mask = ~ctr_t'(0) >> (CtrWidth - k * SliceSize);
      load_and_check(value | mask);
      incr_and_check();
    end
    check_value(val_o, ctr_t'(0), "all-ones increment did not wrap to zero");

    // Lock-up, request dropped while the increment runs
    @(posedge clk_i);
    cmd_req_i <= 1'b1;
    cmd_i.op  <= CTR_OP_INCR;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_flag(cmd_ack_o, 1'b0, "cmd_ack_o high in the middle of an increment");
    @(posedge clk_i);
    cmd_req_i <= 1'b0;
    repeat (3) @(negedge clk_i);
    check_flag(alert_o, 1'b1, "alert_o not raised on protocol violation");

    // Locked unit ignores new requests
    @(posedge clk_i);
    cmd_req_i <= 1'b1;
    cmd_i.op  <= CTR_OP_LOAD;
    repeat (LockWait) begin
      @(negedge clk_i);
      check_flag(alert_o, 1'b1, "alert_o not sticky");
      check_flag(cmd_ack_o, 1'b0, "cmd_ack_o given while locked");
      check_flag(val_req_o, 1'b0, "val_req_o raised while locked");
    end
    @(posedge clk_i);
    cmd_req_i <= 1'b0;
    @(negedge clk_i);

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
hw/ctr_pkg.sv
hw/ctr_cmd_intake.sv
hw/ctr_slice_store.sv
hw/ctr_incr_fsm.sv
hw/ctr_value_out.sv
hw/ctr_unit_top.sv
verification/tb_ctr_unit.sv
